// File: program_loader_top.f
hdl/loader_pkg.sv
hdl/fetch_port_if.sv
hdl/uart_rx.sv
hdl/instruction_loader.sv
hdl/instruction_memory.sv
hdl/instruction_fetch.sv
hdl/program_loader_top.sv
testbench/program_loader_tb.sv

// File: run_sim.sh
#!/bin/sh
# Builds the testbench with Verilator, runs it and looks for the pass line.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
   --top-module program_loader_tb \
   -f program_loader_top.f

status=0
output=$(./obj_dir/Vprogram_loader_tb 2>&1) || status=$?
printf '%s\n' "$output"

if printf '%s\n' "$output" | grep -qx "PASS: all tests"; then
   exit 0
else
   echo "Simulation did not pass (exit status $status)"
   exit 1
fi

// File: testbench/program_loader_tb.sv
// Testbench for the serial program loader. Sends programs as 8N1 frames on rx
// and checks the replayed instruction stream against a reference model.
`timescale 1ns/1ps
`default_nettype none

module program_loader_tb;
   import loader_pkg::*;

   // Words sent in all tests, plus one whole byte and one partial byte around the reset.
   localparam int TOTAL_WORDS    = 24;
   localparam int TOTAL_BYTES    = TOTAL_WORDS * 4 + 2;
   localparam int TIMEOUT_CYCLES = TOTAL_BYTES * 10 * CLKS_PER_BIT + 2000;

   logic        clk;
   logic        reset;
   logic        rx;
   logic        in_execution;
   logic        instr_valid;
   logic        program_done;
   logic [7:0]  instr_pc;
   logic [31:0] instr_data;

   integer      seed;
   int          cycle_count = 0;
   int          beat_count = 0;
   string       current_test = "reset";
   word_t       sent_q[$];
   word_t       expected_q[$];

   program_loader_top program_loader_top_inst (
      .clk          (clk),
      .reset        (reset),
      .rx           (rx),
      .in_execution (in_execution),
      .instr_valid  (instr_valid),
      .program_done (program_done),
      .instr_pc     (instr_pc),
      .instr_data   (instr_data)
   );

   initial begin
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

   task automatic abort_run(input string reason);
      $display("%s", reason);
      $display("FAIL: see errors above");
      $fatal(1, "Simulation stopped after an error.");
   endtask

   task automatic check_value(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
      if (expected !== actual) begin
         abort_run($sformatf("MISMATCH %s: expected %h, actual %h", name, expected, actual));
      end
   endtask

   // Reference model. The stream replays the words written since the last
   // entry into loading mode, in order, from pc 0. Toggle words are never stored.
   function automatic void build_expected();
      expected_q.delete();
      foreach (sent_q[i]) begin
         if (sent_q[i] != TOGGLE_WORD && expected_q.size() < MEM_DEPTH - 1) begin
            expected_q.push_back(sent_q[i]);
         end
      end
   endfunction

   function automatic word_t random_word();
      word_t w;
      w = $random(seed);
      if (w == TOGGLE_WORD) w = 32'h1234_5678;
      return w;
   endfunction

   // One frame: start bit, eight data bits LSB first, stop bit.
   task automatic send_byte(input byte_t value);
      rx = 1'b0;
      repeat (CLKS_PER_BIT) @(negedge clk);
      for (int i = 0; i < 8; i++) begin
         rx = value[i];
         repeat (CLKS_PER_BIT) @(negedge clk);
      end
      rx = 1'b1;
      repeat (CLKS_PER_BIT) @(negedge clk);
   endtask

   task automatic send_partial_byte(input byte_t value, input int bits);
      rx = 1'b0;
      repeat (CLKS_PER_BIT) @(negedge clk);
      for (int i = 0; i < bits; i++) begin
         rx = value[i];
         repeat (CLKS_PER_BIT) @(negedge clk);
      end
   endtask

   task automatic send_word(input word_t w);
      send_byte(w[31:24]);
      send_byte(w[23:16]);
      send_byte(w[15:8]);
      send_byte(w[7:0]);
   endtask

   task automatic load_program_word(input word_t w);
      sent_q.push_back(w);
      send_word(w);
   endtask

   task automatic apply_reset();
      reset = 1'b1;
      rx    = 1'b1;
      repeat (4) @(negedge clk);
      reset = 1'b0;
   endtask

   task automatic wait_for_mode(input logic value);
      while (in_execution !== value) @(negedge clk);
   endtask

   task automatic wait_for_done();
      while (program_done !== 1'b1) @(negedge clk);
   endtask

   // Start a new program in loading mode with an empty reference list.
   task automatic start_program(input string name);
      current_test = name;
      sent_q.delete();
      build_expected();
      beat_count = 0;
   endtask

   task automatic run_program(input int expected_beats);
      build_expected();
      send_word(TOGGLE_WORD);
      wait_for_mode(1'b1);
      wait_for_done();
      check_value({current_test, " beat count"}, expected_beats, beat_count);
   endtask

   // Every output beat is checked in order against the reference list.
   always @(negedge clk) begin
      if (!reset && instr_valid) begin
         if (beat_count >= expected_q.size()) begin
            abort_run($sformatf("Unexpected instruction beat at pc %0d in test %s",
                                instr_pc, current_test));
         end else begin
            check_value({current_test, " pc"}, beat_count, 32'(instr_pc));
            check_value({current_test, " data"}, expected_q[beat_count], instr_data);
            beat_count++;
         end
      end
   end

   always @(posedge clk) begin
      cycle_count++;
      if (cycle_count >= TIMEOUT_CYCLES) begin
         abort_run($sformatf("The run hung in test %s and hit the limit of %0d cycles",
                             current_test, TIMEOUT_CYCLES));
      end
   end

   initial begin
      seed  = 32'hefa3b969;
      rx    = 1'b1;
      reset = 1'b1;
      @(negedge clk);
      apply_reset();

      // Idle after reset, and bytes alone never start execution.
      start_program("idle_after_reset");
      check_value({current_test, " in_execution"}, 0, 32'(in_execution));
      check_value({current_test, " instr_valid"}, 0, 32'(instr_valid));
      check_value({current_test, " program_done"}, 0, 32'(program_done));
      send_word(random_word());
      send_word(random_word());
      repeat (4) @(negedge clk);
      check_value({current_test, " in_execution"}, 0, 32'(in_execution));
      check_value({current_test, " program_done"}, 0, 32'(program_done));
      apply_reset();

      start_program("load_and_run");
      repeat (8) load_program_word(random_word());
      run_program(8);

      // Words received in execution mode are ignored.
      current_test = "words_in_execution";
      repeat (3) send_word(random_word());
      repeat (4) @(negedge clk);
      check_value({current_test, " in_execution"}, 1, 32'(in_execution));
      check_value({current_test, " program_done"}, 1, 32'(program_done));
      check_value({current_test, " beat count"}, 8, beat_count);

      send_word(TOGGLE_WORD);
      wait_for_mode(1'b0);
      start_program("reload_shorter");
      check_value({current_test, " program_done"}, 0, 32'(program_done));
      repeat (3) load_program_word(random_word());
      run_program(3);

      send_word(TOGGLE_WORD);
      wait_for_mode(1'b0);
      start_program("empty_program");
      run_program(0);

      // One whole byte leaves the byte position at 1. Then a frame is cut
      // in half with reset, and loading must start clean.
      current_test = "reset_mid_byte";
      send_byte(8'hc3);
      send_partial_byte(8'h5a, 4);
      apply_reset();
      start_program("reset_mid_byte");
      check_value({current_test, " in_execution"}, 0, 32'(in_execution));
      repeat (2) load_program_word(random_word());
      run_program(2);

      $display("PASS: all tests");
      $finish;
   end

endmodule

`default_nettype wire

// File: hdl/program_loader_top.sv
// Top level of the serial program loader. Bytes from rx are packed into
// words, stored, and replayed on the instr_* outputs in execution mode.
`timescale 1ns/1ps
`default_nettype none

module program_loader_top (
   input  logic        clk,
   input  logic        reset,
   input  logic        rx,
   output logic        in_execution,
   output logic        instr_valid,
   output logic        program_done,
   output logic [7:0]  instr_pc,
   output logic [31:0] instr_data
);
   import loader_pkg::*;

   logic       byte_valid;
   byte_t      rx_byte;
   logic       write_enable;
   word_addr_t write_address;
   word_addr_t word_count;
   word_t      write_data;

   fetch_port_if fetch_port ();

   uart_rx uart_rx_inst (
      .clk        (clk),
      .reset      (reset),
      .rx         (rx),
      .byte_valid (byte_valid),
      .rx_byte    (rx_byte)
   );

   instruction_loader instruction_loader_inst (
      .clk           (clk),
      .reset         (reset),
      .byte_valid    (byte_valid),
      .rx_byte       (rx_byte),
      .in_execution  (in_execution),
      .write_enable  (write_enable),
      .write_address (write_address),
      .word_count    (word_count),
      .write_data    (write_data)
   );

   instruction_memory instruction_memory_inst (
      .clk           (clk),
      .reset         (reset),
      .write_enable  (write_enable),
      .write_address (write_address),
      .write_data    (write_data),
      .port          (fetch_port.memory)
   );

   instruction_fetch instruction_fetch_inst (
      .clk          (clk),
      .reset        (reset),
      .in_execution (in_execution),
      .word_count   (word_count),
      .port         (fetch_port.fetch),
      .instr_valid  (instr_valid),
      .program_done (program_done),
      .instr_pc     (instr_pc),
      .instr_data   (instr_data)
   );

endmodule

`default_nettype wire

// File: hdl/instruction_fetch.sv
// Streams the stored program out of the instruction memory when execution
// mode is entered, one word per cycle from address 0.
`timescale 1ns/1ps
`default_nettype none

module instruction_fetch (
   input  logic                   clk,
   input  logic                   reset,
   input  logic                   in_execution,
   input  loader_pkg::word_addr_t word_count,
   fetch_port_if.fetch            port,
   output logic                   instr_valid,
   output logic                   program_done,
   output loader_pkg::word_addr_t instr_pc,
   output loader_pkg::word_t      instr_data
);
   import loader_pkg::*;

   fetch_state_t state;
   logic         in_exec_q;
   word_addr_t   last_address;
   word_addr_t   pc_q;

   assign last_address = word_count - 1'b1;

   always_ff @(posedge clk) begin
      if (reset) begin
         state             <= FETCH_IDLE;
         in_exec_q         <= 1'b0;
         port.read_enable  <= 1'b0;
         port.read_address <= '0;
      end else begin
         in_exec_q <= in_execution;
         if (!in_execution) begin
            state            <= FETCH_IDLE;
            port.read_enable <= 1'b0;
         end else begin
            case (state)
               FETCH_IDLE: begin
                  if (!in_exec_q) begin
                     state             <= FETCH_RUN;
                     port.read_address <= '0;
                     port.read_enable  <= (word_count != '0);
                  end
               end
               // The last read returns in the cycle after the enable drops.
               FETCH_RUN: begin
                  if (port.read_enable) begin
                     if (port.read_address == last_address) begin
                        port.read_enable <= 1'b0;
                     end else begin
                        port.read_address <= port.read_address + 1'b1;
                     end
                  end else begin
                     state <= FETCH_DONE;
                  end
               end
               default: state <= FETCH_DONE;
            endcase
         end
      end
   end

   // Keep the address of each read so it lines up with its data.
   always_ff @(posedge clk) begin
      if (port.read_enable) pc_q <= port.read_address;
   end

   assign instr_valid  = port.read_valid;
   assign instr_data   = port.read_data;
   assign instr_pc     = pc_q;

   // The state leaves FETCH_DONE one cycle after the mode falls, so the
   // mode level ends program_done at the same edge as in_execution.
   assign program_done = (state == FETCH_DONE) && in_execution;

   // word_count comes from the loader and must bound every read.
   a_read_in_range: assert property (@(posedge clk) disable iff (reset)
      port.read_enable |-> (port.read_address < word_count));

endmodule

`default_nettype wire

// File: hdl/instruction_memory.sv
// Instruction store with one synchronous write port from the loader
// and one registered read port towards the fetch unit.
`timescale 1ns/1ps
`default_nettype none

module instruction_memory (
   input  logic                   clk,
   input  logic                   reset,
   input  logic                   write_enable,
   input  loader_pkg::word_addr_t write_address,
   input  loader_pkg::word_t      write_data,
   fetch_port_if.memory           port
);
   import loader_pkg::*;

   word_t mem [MEM_DEPTH];

   always_ff @(posedge clk) begin
      if (write_enable) begin
         mem[write_address] <= write_data;
      end
   end

   // Read data is registered, one cycle after the enable.
   always_ff @(posedge clk) begin
      if (port.read_enable) begin
         port.read_data <= mem[port.read_address];
      end
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         port.read_valid <= 1'b0;
      end else begin
         port.read_valid <= port.read_enable;
      end
   end

endmodule

`default_nettype wire

// File: hdl/instruction_loader.sv
// Packs received bytes into 32-bit words, MSB first, and writes them to the
// instruction memory in loading mode. The toggle word flips the mode.
`timescale 1ns/1ps
`default_nettype none

module instruction_loader (
   input  logic                   clk,
   input  logic                   reset,
   input  logic                   byte_valid,
   input  loader_pkg::byte_t      rx_byte,
   output logic                   in_execution,
   output logic                   write_enable,
   output loader_pkg::word_addr_t write_address,
   output loader_pkg::word_addr_t word_count,
   output loader_pkg::word_t      write_data
);
   import loader_pkg::*;

   logic [1:0] byte_pos;
   word_t      word_reg;
   word_t      full_word;
   logic       word_done;

   // The word as it stands once the current byte lands in the lowest lane.
   // Used for the toggle check so that the fourth byte is included.
   assign full_word = {word_reg[31:8], rx_byte};
   assign word_done = byte_valid && (byte_pos == 2'd3);

   always_ff @(posedge clk) begin
      if (byte_valid) begin
         case (byte_pos)
            2'd0:    word_reg[31:24] <= rx_byte;
            2'd1:    word_reg[23:16] <= rx_byte;
            2'd2:    word_reg[15:8]  <= rx_byte;
            default: word_reg[7:0]   <= rx_byte;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         byte_pos      <= 2'd0;
         in_execution  <= 1'b0;
         write_enable  <= 1'b0;
         write_address <= '0;
      end else begin
         write_enable <= 1'b0;
         if (byte_valid) byte_pos <= byte_pos + 2'd1;

         // The address moves on at the edge that performs the write.
         if (write_enable) write_address <= write_address + 1'b1;

         if (word_done) begin
            if (full_word == TOGGLE_WORD) begin
               in_execution <= !in_execution;
               // Going back to loading starts a fresh program at address 0.
               if (in_execution) write_address <= '0;
            end else if (!in_execution) begin
               write_enable <= 1'b1;
            end
         end
      end
   end

   assign write_data = word_reg;

   // Next free address, which is also the number of words stored.
   assign word_count = write_address;

   a_no_write_in_exec: assert property (@(posedge clk) disable iff (reset)
      in_execution |-> !write_enable);

endmodule

`default_nettype wire

// File: hdl/uart_rx.sv
// 8N1 serial receiver. Pulses byte_valid for one cycle per good frame,
// with the byte on rx_byte in the same cycle.
`timescale 1ns/1ps
`default_nettype none

module uart_rx (
   input  logic              clk,
   input  logic              reset,
   input  logic              rx,
   output logic              byte_valid,
   output loader_pkg::byte_t rx_byte
);
   import loader_pkg::*;

   typedef enum logic [1:0] {
      RX_IDLE,
      RX_START,
      RX_DATA,
      RX_STOP
   } rx_state_t;

   rx_state_t            state;
   logic                 rx_meta;
   logic                 rx_sync;
   logic [CLK_CNT_W-1:0] clk_count;
   logic [2:0]           bit_index;
   byte_t                data_shift;

   // The line idles high, so the synchronizer comes out of reset high too.
   always_ff @(posedge clk) begin
      if (reset) begin
         rx_meta <= 1'b1;
         rx_sync <= 1'b1;
      end else begin
         rx_meta <= rx;
         rx_sync <= rx_meta;
      end
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         state      <= RX_IDLE;
         clk_count  <= '0;
         bit_index  <= '0;
         byte_valid <= 1'b0;
      end else begin
         byte_valid <= 1'b0;
         clk_count  <= clk_count + 1'b1;
         case (state)
            RX_IDLE: begin
               clk_count <= '0;
               if (!rx_sync) state <= RX_START;
            end
            // Check the start bit again at its middle to reject glitches.
            RX_START: begin
               if (clk_count == CLK_CNT_W'(CLKS_PER_BIT / 2 - 1)) begin
                  clk_count <= '0;
                  bit_index <= '0;
                  state     <= rx_sync ? RX_IDLE : RX_DATA;
               end
            end
            RX_DATA: begin
               if (clk_count == CLK_CNT_W'(CLKS_PER_BIT - 1)) begin
                  clk_count  <= '0;
                  bit_index  <= bit_index + 1'b1;
                  if (bit_index == 3'd7) state <= RX_STOP;
               end
            end
            // A low stop bit drops the byte silently.
            RX_STOP: begin
               if (clk_count == CLK_CNT_W'(CLKS_PER_BIT - 1)) begin
                  byte_valid <= rx_sync;
                  state      <= RX_IDLE;
               end
            end
            default: state <= RX_IDLE;
         endcase
      end
   end

   // Data arrives LSB first, so shift in from the top.
   always_ff @(posedge clk) begin
      if (state == RX_DATA && clk_count == CLK_CNT_W'(CLKS_PER_BIT - 1)) begin
         data_shift <= {rx_sync, data_shift[7:1]};
      end
   end

   assign rx_byte = data_shift;

   // Frames are far apart, so a valid byte is always a single-cycle pulse.
   a_single_pulse: assert property (@(posedge clk) disable iff (reset)
      byte_valid |=> !byte_valid);

endmodule

`default_nettype wire

// File: hdl/fetch_port_if.sv
// Read port between the instruction memory and the fetch unit.
// Data and valid follow a read enable by exactly one cycle.
`timescale 1ns/1ps
`default_nettype none

interface fetch_port_if;
   import loader_pkg::*;

   logic       read_enable;
   word_addr_t read_address;
   word_t      read_data;
   logic       read_valid;

   modport memory (
      input  read_enable,
      input  read_address,
      output read_data,
      output read_valid
   );

   modport fetch (
      output read_enable,
      output read_address,
      input  read_data,
      input  read_valid
   );

endinterface

`default_nettype wire

// File: hdl/loader_pkg.sv
// Shared types and constants for the serial program loader.
// Every design module imports what it needs from this package.
`default_nettype none

package loader_pkg;

   // One received serial byte.
   typedef logic [7:0] byte_t;

   // One instruction word as stored in the memory.
   typedef logic [31:0] word_t;

   // Instruction memory address, also used for the program word count.
   typedef logic [7:0] word_addr_t;

   // Number of words in the instruction memory.
   localparam int MEM_DEPTH = 256;

   // Clock cycles per serial bit on the rx line.
   localparam int CLKS_PER_BIT = 8;

   // Width of the per-bit clock counter in the receiver.
   localparam int CLK_CNT_W = $clog2(CLKS_PER_BIT);

   // Word that switches between loading and execution mode. It is never stored.
   localparam word_t TOGGLE_WORD = 32'hffff_ffff;

   // States of the fetch unit.
   typedef enum logic [1:0] {
      FETCH_IDLE,
      FETCH_RUN,
      FETCH_DONE
   } fetch_state_t;

endpackage

`default_nettype wire
